//--- naxi_pkg.sv
package naxi_pkg;

  // ---------------------------------------------------------
  // Field widths
  // ---------------------------------------------------------
  localparam int xtyp_bits = 3;
  localparam int xatr_bits = 3;
  localparam int xsiz_bits = 8;
  localparam int xadr_bits = 32;

  // ---------------------------------------------------------
  // Command type encodings
  // ---------------------------------------------------------
  localparam logic [xtyp_bits-1:0] typ_write = 3'd0;
  localparam logic [xtyp_bits-1:0] typ_read  = 3'd1;
  localparam logic [xtyp_bits-1:0] typ_flush = 3'd2;
  localparam logic [xtyp_bits-1:0] typ_inval = 3'd3; // Codes above this are illegal

  // Command attribute bit positions
  localparam int cattr_ack   = 0; // Slave must send a response
  localparam int cattr_cache = 1;
  localparam int cattr_index = 2; // Index operation

  // Data and response attribute bit position
  localparam int attr_last = 0;

  // Width of a beat count on a bus of data_width bits.
  // Covers the largest size in beats plus the partial head and tail beats.
  function automatic int beat_cnt_bits(input int data_width);
    return xsiz_bits + 1 - $clog2(data_width / 8);
  endfunction

endpackage

//--- mon_pkg.sv
package mon_pkg;

  localparam int num_err = 20;

  // ---------------------------------------------------------
  // Command channel rules
  // ---------------------------------------------------------
  localparam int err_bad_type     = 0;
  localparam int err_id_range     = 1;
  localparam int err_wr_no_data   = 2;  // Write without matching data beat
  localparam int err_wr_off       = 3;
  localparam int err_fl_off       = 4;
  localparam int err_iv_off       = 5;
  localparam int err_data_on_nowr = 6;
  localparam int err_line_align   = 7;
  localparam int err_not_cache    = 8;
  localparam int err_flit_cross   = 9;
  localparam int err_too_big      = 10; // Larger than one line
  localparam int err_beats_high   = 11;
  localparam int err_beats_zero   = 12;

  // ---------------------------------------------------------
  // Write data and stall rules
  // ---------------------------------------------------------
  localparam int err_data_no_last = 13;
  localparam int err_data_id_chg  = 14;
  localparam int err_stall_mix    = 15;

  // Response channel rules
  localparam int err_rsp_unexp    = 16;
  localparam int err_rsp_no_last  = 17;
  localparam int err_rsp_id_chg   = 18;
  localparam int err_rsp_stall    = 19;

endpackage

//--- naxi_cmd_check.sv
`timescale 1ns/1ns

module naxi_cmd_check #(
  parameter int id_bits     = 3,
  parameter int data_width  = 64,
  parameter int max_beats   = 4,
  parameter int allow_write = 0,
  parameter int allow_flush = 1,
  parameter int allow_inval = 1
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           creq_valid,
  input  logic [naxi_pkg::xtyp_bits-1:0]                 creq_type,
  input  logic [naxi_pkg::xatr_bits-1:0]                 creq_attr,
  input  logic [naxi_pkg::xsiz_bits-1:0]                 creq_size,
  input  logic [id_bits-1:0]                             creq_id,
  input  logic [naxi_pkg::xadr_bits-1:0]                 creq_addr,
  input  logic                                           creq_rdstall,
  input  logic                                           creq_wrstall,
  input  logic                                           dreq_valid,
  input  logic [id_bits-1:0]                             dreq_id,
  input  logic [naxi_pkg::xatr_bits-1:0]                 dreq_attr,
  input  logic                                           dreq_stall,
  output logic [mon_pkg::num_err-1:0]                    cmd_err,
  output logic                                           pend_we,
  output logic [naxi_pkg::beat_cnt_bits(data_width)-1:0] pend_beats,
  output logic                                           pend_read,
  output logic                                           pend_ack
);
  import naxi_pkg::*;
  import mon_pkg::*;

  localparam int byte_bits  = $clog2(data_width / 8);
  localparam int line_bits  = byte_bits + $clog2(max_beats);
  localparam int line_bytes = max_beats * (data_width / 8);
  localparam int cnt_bits   = beat_cnt_bits(data_width);

  logic                is_write;
  logic                is_read;
  logic                is_maint;
  logic                legal_type;
  logic [xsiz_bits:0]  size_act;
  logic [byte_bits:0]  size_ovr;
  logic [xadr_bits:0]  start_addr;
  logic [xadr_bits:0]  end_addr;
  logic [cnt_bits-1:0] beat_cnt;
  logic                any_stall;
  logic                all_stall;
  logic                wr_start;
  logic [id_bits-1:0]  wr_id;
  logic [cnt_bits-1:0] wr_left;
  logic                wr_busy;

  assign is_write   = creq_type == typ_write;
  assign is_read    = creq_type == typ_read;
  assign is_maint   = (creq_type == typ_flush) || (creq_type == typ_inval);
  assign legal_type = is_write || is_read || is_maint;

  // ---------------------------------------------------------
  // Size and beat arithmetic
  // ---------------------------------------------------------
  assign size_act   = (creq_size == '0) ? {1'b1, {xsiz_bits{1'b0}}} : {1'b0, creq_size};
  assign size_ovr   = {1'b0, creq_addr[byte_bits-1:0]} + {1'b0, creq_size[byte_bits-1:0]};
  assign beat_cnt   = cnt_bits'(size_act >> byte_bits) + cnt_bits'(size_ovr[byte_bits])
                    + cnt_bits'(|size_ovr[byte_bits-1:0]);
  assign start_addr = {1'b0, creq_addr};
  assign end_addr   = start_addr + {{(xadr_bits - xsiz_bits){1'b0}}, size_act} - 1'b1;

  assign any_stall = creq_rdstall || creq_wrstall || dreq_stall;
  assign all_stall = creq_rdstall && creq_wrstall && dreq_stall;

  // ---------------------------------------------------------
  // Rule checks
  // ---------------------------------------------------------
  always_comb begin
    cmd_err = '0;
    if (creq_valid) begin
      cmd_err[err_bad_type]     = !legal_type;
      cmd_err[err_wr_no_data]   = is_write && !(dreq_valid && (dreq_id == creq_id));
      cmd_err[err_wr_off]       = is_write && (allow_write == 0);
      cmd_err[err_fl_off]       = (creq_type == typ_flush) && (allow_flush == 0);
      cmd_err[err_iv_off]       = (creq_type == typ_inval) && (allow_inval == 0);
      cmd_err[err_data_on_nowr] = (is_read || is_maint) && dreq_valid;
      cmd_err[err_line_align]   = is_maint && (creq_addr[line_bits-1:0] != '0);
      cmd_err[err_not_cache]    = is_maint && !creq_attr[cattr_cache];
      cmd_err[err_flit_cross]   = start_addr[xadr_bits:line_bits] != end_addr[xadr_bits:line_bits];
      cmd_err[err_too_big]      = size_act > line_bytes;
      cmd_err[err_beats_high]   = beat_cnt > max_beats;
      cmd_err[err_beats_zero]   = beat_cnt == '0;
    end
    cmd_err[err_data_no_last] = dreq_valid && (wr_left == 1) && !dreq_attr[attr_last];
    cmd_err[err_data_id_chg]  = dreq_valid && wr_busy && (dreq_id != wr_id);
    cmd_err[err_stall_mix]    = any_stall && !all_stall;
  end

  // ---------------------------------------------------------
  // Write burst tracking
  // ---------------------------------------------------------
  assign wr_start = creq_valid && is_write && dreq_valid && !any_stall;
  assign wr_busy  = wr_left != '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_left <= '0;
    end else if (wr_start) begin
      wr_left <= beat_cnt - 1'b1; // First beat rides with the command
    end else if (dreq_valid && !dreq_stall && wr_busy) begin
      wr_left <= wr_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start) begin
      wr_id <= creq_id;
    end
  end

  // Every command is recorded, stalled or not
  assign pend_we    = creq_valid;
  assign pend_beats = beat_cnt;
  assign pend_read  = is_read;
  assign pend_ack   = creq_attr[cattr_ack];

endmodule

//--- naxi_pend_table.sv
`timescale 1ns/1ns

module naxi_pend_table #(
  parameter int id_bits    = 3,
  parameter int data_width = 64
) (
  input  logic                                           clk,
  input  logic                                           pend_we,
  input  logic [id_bits-1:0]                             wr_id,
  input  logic [naxi_pkg::beat_cnt_bits(data_width)-1:0] pend_beats,
  input  logic                                           pend_read,
  input  logic                                           pend_ack,
  input  logic [id_bits-1:0]                             rd_id,
  output logic [naxi_pkg::beat_cnt_bits(data_width)-1:0] ent_beats,
  output logic                                           ent_read,
  output logic                                           ent_ack
);
  import naxi_pkg::*;

  localparam int num_ids  = 1 << id_bits;
  localparam int cnt_bits = beat_cnt_bits(data_width);

  // One entry per outstanding id
  logic [cnt_bits-1:0] beats_mem [num_ids];
  logic                read_mem  [num_ids];
  logic                ack_mem   [num_ids];

  // A later command to the same id overwrites the entry
  always_ff @(posedge clk) begin
    if (pend_we) begin
      beats_mem[wr_id] <= pend_beats;
      read_mem[wr_id]  <= pend_read;
      ack_mem[wr_id]   <= pend_ack;
    end
  end

  // Lookup for the response side, old contents in a same-cycle write
  assign ent_beats = beats_mem[rd_id];
  assign ent_read  = read_mem[rd_id];
  assign ent_ack   = ack_mem[rd_id];

endmodule

//--- naxi_resp_check.sv
`timescale 1ns/1ns

module naxi_resp_check #(
  parameter int id_bits    = 3,
  parameter int data_width = 64
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           rreq_valid,
  input  logic [id_bits-1:0]                             rreq_id,
  input  logic [naxi_pkg::xatr_bits-1:0]                 rreq_attr,
  input  logic                                           rreq_stall,
  input  logic [naxi_pkg::beat_cnt_bits(data_width)-1:0] ent_beats,
  input  logic                                           ent_read,
  input  logic                                           ent_ack,
  output logic [mon_pkg::num_err-1:0]                    rsp_err
);
  import naxi_pkg::*;
  import mon_pkg::*;

  localparam int cnt_bits = beat_cnt_bits(data_width);

  logic                rsp_beat;
  logic                rd_beat;
  logic                rsp_busy;
  logic [id_bits-1:0]  rsp_id;
  logic [id_bits-1:0]  rsp_id_nxt;
  logic [cnt_bits-1:0] rsp_left;
  logic [cnt_bits-1:0] rsp_left_nxt;

  assign rsp_beat = rreq_valid && !rreq_stall;
  assign rd_beat  = rsp_beat && ent_read; // Only reads carry multi-beat data
  assign rsp_busy = rsp_left != '0;

  // ---------------------------------------------------------
  // Response burst tracking
  // ---------------------------------------------------------
  always_comb begin
    rsp_left_nxt = rsp_left;
    rsp_id_nxt   = rsp_id;
    if (rd_beat && !rsp_busy) begin
      rsp_left_nxt = ent_beats - 1'b1;
      rsp_id_nxt   = rreq_id;
    end else if (rd_beat) begin
      rsp_left_nxt = rsp_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_left <= '0;
    end else begin
      rsp_left <= rsp_left_nxt;
    end
  end

  always_ff @(posedge clk) begin
    rsp_id <= rsp_id_nxt;
  end

  // ---------------------------------------------------------
  // Rule checks
  // ---------------------------------------------------------
  always_comb begin
    rsp_err                  = '0;
    rsp_err[err_rsp_unexp]   = rreq_valid && !ent_ack;
    rsp_err[err_rsp_no_last] = rsp_beat && (rsp_left_nxt == '0) && !rreq_attr[attr_last];
    rsp_err[err_rsp_id_chg]  = rreq_valid && rsp_busy && (rreq_id != rsp_id);
    rsp_err[err_rsp_stall]   = rreq_stall; // Slave may never stall responses
  end

endmodule

//--- naxi_slave_monitor.sv
`timescale 1ns/1ns

module naxi_slave_monitor #(
  parameter int id_bits     = 3,
  parameter int data_width  = 64,
  parameter int max_beats   = 4,
  parameter int allow_write = 0,
  parameter int allow_flush = 1,
  parameter int allow_inval = 1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           creq_valid,
  input  logic [naxi_pkg::xtyp_bits-1:0] creq_type,
  input  logic [naxi_pkg::xatr_bits-1:0] creq_attr,
  input  logic [naxi_pkg::xsiz_bits-1:0] creq_size,
  input  logic [id_bits-1:0]             creq_id,
  input  logic [naxi_pkg::xadr_bits-1:0] creq_addr,
  input  logic                           creq_rdstall,
  input  logic                           creq_wrstall,
  input  logic                           dreq_valid,
  input  logic [id_bits-1:0]             dreq_id,
  input  logic [naxi_pkg::xatr_bits-1:0] dreq_attr,
  input  logic                           dreq_stall,
  input  logic                           rreq_valid,
  input  logic [id_bits-1:0]             rreq_id,
  input  logic [naxi_pkg::xatr_bits-1:0] rreq_attr,
  input  logic                           rreq_stall,
  output logic [mon_pkg::num_err-1:0]    err
);
  import naxi_pkg::*;
  import mon_pkg::*;

  localparam int cnt_bits = beat_cnt_bits(data_width);

  logic [num_err-1:0]  cmd_err;
  logic [num_err-1:0]  rsp_err;
  logic                pend_we;
  logic [cnt_bits-1:0] pend_beats;
  logic                pend_read;
  logic                pend_ack;
  logic [cnt_bits-1:0] ent_beats;
  logic                ent_read;
  logic                ent_ack;

  naxi_cmd_check #(
    .id_bits     (id_bits),
    .data_width  (data_width),
    .max_beats   (max_beats),
    .allow_write (allow_write),
    .allow_flush (allow_flush),
    .allow_inval (allow_inval)
  ) u_cmd_check (
    .clk          (clk),
    .rst          (rst),
    .creq_valid   (creq_valid),
    .creq_type    (creq_type),
    .creq_attr    (creq_attr),
    .creq_size    (creq_size),
    .creq_id      (creq_id),
    .creq_addr    (creq_addr),
    .creq_rdstall (creq_rdstall),
    .creq_wrstall (creq_wrstall),
    .dreq_valid   (dreq_valid),
    .dreq_id      (dreq_id),
    .dreq_attr    (dreq_attr),
    .dreq_stall   (dreq_stall),
    .cmd_err      (cmd_err),
    .pend_we      (pend_we),
    .pend_beats   (pend_beats),
    .pend_read    (pend_read),
    .pend_ack     (pend_ack)
  );

  naxi_pend_table #(
    .id_bits    (id_bits),
    .data_width (data_width)
  ) u_pend_table (
    .clk        (clk),
    .pend_we    (pend_we),
    .wr_id      (creq_id),
    .pend_beats (pend_beats),
    .pend_read  (pend_read),
    .pend_ack   (pend_ack),
    .rd_id      (rreq_id),
    .ent_beats  (ent_beats),
    .ent_read   (ent_read),
    .ent_ack    (ent_ack)
  );

  naxi_resp_check #(
    .id_bits    (id_bits),
    .data_width (data_width)
  ) u_resp_check (
    .clk        (clk),
    .rst        (rst),
    .rreq_valid (rreq_valid),
    .rreq_id    (rreq_id),
    .rreq_attr  (rreq_attr),
    .rreq_stall (rreq_stall),
    .ent_beats  (ent_beats),
    .ent_read   (ent_read),
    .ent_ack    (ent_ack),
    .rsp_err    (rsp_err)
  );

  // One pulse per offending cycle, a cycle after the inputs
  always_ff @(posedge clk) begin
    if (rst) begin
      err <= '0;
    end else begin
      err <= cmd_err | rsp_err;
    end
  end

endmodule

//--- tb_naxi_slave_monitor.sv
`timescale 1ns/1ns

module tb_naxi_slave_monitor;
  import naxi_pkg::*;
  import mon_pkg::*;

  localparam int id_bits     = 3;
  localparam int data_width  = 64;
  localparam int max_beats   = 4;
  localparam int allow_write = 0;
  localparam int allow_flush = 1;
  localparam int allow_inval = 1;
  localparam int line_bits   = $clog2(data_width / 8) + $clog2(max_beats);
  localparam int max_lines   = 2000; // Bound on lines read from the data file
  localparam int clear_wait  = 16;
  localparam int num_fields  = 19;

  logic                 clk;
  logic                 rst;
  logic                 creq_valid;
  logic [xtyp_bits-1:0] creq_type;
  logic [xatr_bits-1:0] creq_attr;
  logic [xsiz_bits-1:0] creq_size;
  logic [id_bits-1:0]   creq_id;
  logic [xadr_bits-1:0] creq_addr;
  logic                 creq_rdstall;
  logic                 creq_wrstall;
  logic                 dreq_valid;
  logic [id_bits-1:0]   dreq_id;
  logic [xatr_bits-1:0] dreq_attr;
  logic                 dreq_stall;
  logic                 rreq_valid;
  logic [id_bits-1:0]   rreq_id;
  logic [xatr_bits-1:0] rreq_attr;
  logic                 rreq_stall;
  logic [num_err-1:0]   err;

  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cur_test;
  int          cur_checks;
  int          cur_errs;
  bit          aborted;

  naxi_slave_monitor #(
    .id_bits     (id_bits),
    .data_width  (data_width),
    .max_beats   (max_beats),
    .allow_write (allow_write),
    .allow_flush (allow_flush),
    .allow_inval (allow_inval)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .creq_valid   (creq_valid),
    .creq_type    (creq_type),
    .creq_attr    (creq_attr),
    .creq_size    (creq_size),
    .creq_id      (creq_id),
    .creq_addr    (creq_addr),
    .creq_rdstall (creq_rdstall),
    .creq_wrstall (creq_wrstall),
    .dreq_valid   (dreq_valid),
    .dreq_id      (dreq_id),
    .dreq_attr    (dreq_attr),
    .dreq_stall   (dreq_stall),
    .rreq_valid   (rreq_valid),
    .rreq_id      (rreq_id),
    .rreq_attr    (rreq_attr),
    .rreq_stall   (rreq_stall),
    .err          (err)
  );

  always #4 clk = ~clk; // 8 ns period

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // x^32 + x^22 + x^2 + x + 1
    return {s[30:0], fb};
  endfunction

  // Random line address, offset within the line kept from the file
  task automatic fill_upper_addr(input logic [31:0] addr_in, output logic [31:0] addr_out);
    int b;
    addr_out = addr_in;
    for (b = line_bits; b < xadr_bits; b++) begin
      lfsr_state  = lfsr_step(lfsr_state);
      addr_out[b] = lfsr_state[0];
    end
  endtask

  task automatic init_inputs();
    clk          = 1'b0;
    rst          = 1'b1;
    creq_valid   = 1'b0;
    creq_type    = '0;
    creq_attr    = '0;
    creq_size    = '0;
    creq_id      = '0;
    creq_addr    = '0;
    creq_rdstall = 1'b0;
    creq_wrstall = 1'b0;
    dreq_valid   = 1'b0;
    dreq_id      = '0;
    dreq_attr    = '0;
    dreq_stall   = 1'b0;
    rreq_valid   = 1'b0;
    rreq_id      = '0;
    rreq_attr    = '0;
    rreq_stall   = 1'b0;
  endtask

  task automatic drive_idle();
    creq_valid   <= 1'b0;
    creq_rdstall <= 1'b0;
    creq_wrstall <= 1'b0;
    dreq_valid   <= 1'b0;
    dreq_stall   <= 1'b0;
    rreq_valid   <= 1'b0;
    rreq_stall   <= 1'b0;
  endtask

  task automatic close_test();
    if (cur_test >= 0) begin
      tests_run++;
      if (cur_errs != 0) begin
        tests_failed++;
      end
      $display("test %0d: %0d cycles checked, %0s", cur_test, cur_checks,
               (cur_errs == 0) ? "ok" : "mismatch");
    end
    cur_checks = 0;
    cur_errs   = 0;
  endtask

  task automatic check_err(input int test, input logic [num_err-1:0] exp_val,
                           input logic [num_err-1:0] act_val);
    if (test != cur_test) begin
      close_test();
      cur_test = test;
    end
    checks++;
    cur_checks++;
    if (act_val !== exp_val) begin
      $display("[ERROR] err expected 0x%05h actual 0x%05h (test %0d)", exp_val, act_val, test);
      errors++;
      cur_errs++;
    end
  endtask

  task automatic reset_dut();
    int waited;
    waited = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    while (err !== '0 && waited < clear_wait) begin
      @(negedge clk);
      waited++;
    end
    if (err !== '0) begin
      $display("Timeout: err did not clear within %0d cycles after reset", clear_wait);
      aborted = 1'b1;
    end
  endtask

  // ----------------------------------------------------------
  // One data line per cycle, checked one cycle later
  // ----------------------------------------------------------
  task automatic run_file(input int fd);
    reg   [8*128-1:0] line_buf;
    int               code;
    int               lines;
    int               t;
    int               prev_test;
    bit               have_prev;
    logic [31:0]      rnd, cv, ct, ca, cs, cid, caddr, crs, cws;
    logic [31:0]      dv, did, da, ds, rv, rid, ra, rs, exp_v;
    logic [31:0]      addr_use;
    logic [num_err-1:0] prev_exp;
    lines     = 0;
    have_prev = 1'b0;
    prev_test = 0;
    prev_exp  = '0;
    while (!aborted && !$feof(fd)) begin
      line_buf = '0;
      code     = $fgets(line_buf, fd);
      code     = $sscanf(line_buf, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         t, rnd, cv, ct, ca, cs, cid, caddr, crs, cws,
                         dv, did, da, ds, rv, rid, ra, rs, exp_v);
      lines++;
      if (code == num_fields) begin
        addr_use = caddr;
        if (rnd[0]) begin
          fill_upper_addr(caddr, addr_use);
        end
        @(posedge clk);
        creq_valid   <= cv[0];
        creq_type    <= ct[xtyp_bits-1:0];
        creq_attr    <= ca[xatr_bits-1:0];
        creq_size    <= cs[xsiz_bits-1:0];
        creq_id      <= cid[id_bits-1:0];
        creq_addr    <= addr_use;
        creq_rdstall <= crs[0];
        creq_wrstall <= cws[0];
        dreq_valid   <= dv[0];
        dreq_id      <= did[id_bits-1:0];
        dreq_attr    <= da[xatr_bits-1:0];
        dreq_stall   <= ds[0];
        rreq_valid   <= rv[0];
        rreq_id      <= rid[id_bits-1:0];
        rreq_attr    <= ra[xatr_bits-1:0];
        rreq_stall   <= rs[0];
        @(negedge clk);
        if (have_prev) begin
          check_err(prev_test, prev_exp, err);
        end
        have_prev = 1'b1;
        prev_test = t;
        prev_exp  = exp_v[num_err-1:0];
      end else if (code > 0) begin
        $display("Data file line %0d could not be parsed", lines);
        aborted = 1'b1;
      end
      if (lines > max_lines) begin
        $display("Timeout: data file not finished after %0d lines", max_lines);
        aborted = 1'b1;
      end
    end
    if (have_prev && !aborted) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_err(prev_test, prev_exp, err);
    end
    close_test();
    if (checks == 0) begin
      $display("No stimulus lines were read from the data file");
      aborted = 1'b1;
    end
  endtask

  initial begin
    int fd;
    init_inputs();
    lfsr_state   = 32'h0de7_8e50;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = -1;
    cur_checks   = 0;
    cur_errs     = 0;
    aborted      = 1'b0;
    fd = $fopen("naxi_monitor_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open naxi_monitor_input.txt for reading");
      aborted = 1'b1;
    end else begin
      reset_dut();
      if (!aborted) begin
        run_file(fd);
      end
      $fclose(fd);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- naxi_monitor_input.txt
# test rnd | cmd: valid type attr size id addr rdstall wrstall | data: valid id attr stall
# rsp: valid id attr stall | err expected one cycle later (all hex except test)
# Test 1: legal read, flush, invalidate with well-formed responses
1 1  1 1 3 20 1 00000000 0 0  0 0 0 0  0 0 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 1 0  00000
1 1  1 2 3 20 2 00000000 0 0  0 0 0 0  0 0 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 2 1 0  00000
1 1  1 3 3 20 3 00000000 0 0  0 0 0 0  0 0 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 3 1 0  00000
1 1  1 1 1 08 4 00000018 0 0  0 0 0 0  0 0 0 0  00000
1 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 4 1 0  00000
# Test 2: bad type, disabled write, unaligned flush, uncacheable invalidate
2 0  1 4 1 08 0 00000100 0 0  0 0 0 0  0 0 0 0  00001
2 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
2 0  1 0 1 08 5 00000200 0 0  1 5 1 0  0 0 0 0  00008
2 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
2 0  1 2 3 08 6 00000308 0 0  0 0 0 0  0 0 0 0  00080
2 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
2 0  1 3 1 20 7 00000400 0 0  0 0 0 0  0 0 0 0  00100
2 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
# Test 3: flit crossing, oversize, size 0, too many beats
3 0  1 1 1 08 1 0000003c 0 0  0 0 0 0  0 0 0 0  00200
3 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
3 0  1 1 1 40 2 00000500 0 0  0 0 0 0  0 0 0 0  00e00
3 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
3 0  1 1 1 00 3 00000600 0 0  0 0 0 0  0 0 0 0  00e00
3 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
3 0  1 1 1 20 4 00000704 0 0  0 0 0 0  0 0 0 0  00a00
3 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
# Test 4: early last flag, then id change mid-burst
4 1  1 1 1 20 1 00000000 0 0  0 0 0 0  0 0 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 1 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  20000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
4 1  1 1 1 20 2 00000000 0 0  0 0 0 0  0 0 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 2 0 0  40000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 0 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 1 1 0  00000
4 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
# Test 5: response without ack, stalled responses
5 0  1 1 0 08 5 00000800 0 0  0 0 0 0  0 0 0 0  00000
5 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 5 1 0  10000
5 0  1 1 1 08 6 00000900 0 0  0 0 0 0  0 0 0 0  00000
5 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 6 1 1  80000
5 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 1  80000
5 0  0 0 0 00 0 00000000 0 0  0 0 0 0  1 6 1 0  00000
5 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
# Test 6: mixed stalls flag each cycle, all three together are legal
6 0  0 0 0 00 0 00000000 1 0  0 0 0 0  0 0 0 0  08000
6 0  0 0 0 00 0 00000000 1 0  0 0 0 0  0 0 0 0  08000
6 0  0 0 0 00 0 00000000 1 1  0 0 0 0  0 0 0 0  08000
6 0  0 0 0 00 0 00000000 0 0  0 0 0 1  0 0 0 0  08000
6 0  0 0 0 00 0 00000000 1 1  0 0 0 1  0 0 0 0  00000
6 0  0 0 0 00 0 00000000 1 1  0 0 0 1  0 0 0 0  00000
6 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
6 0  0 0 0 00 0 00000000 0 1  0 0 0 1  0 0 0 0  08000
6 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000
# Test 7: write burst with id change and missing last flag
7 0  1 0 1 20 2 00000a00 0 0  1 2 0 0  0 0 0 0  00008
7 0  0 0 0 00 0 00000000 0 0  1 2 0 0  0 0 0 0  00000
7 0  0 0 0 00 0 00000000 0 0  1 3 0 0  0 0 0 0  04000
7 0  0 0 0 00 0 00000000 0 0  1 2 0 0  0 0 0 0  02000
7 0  0 0 0 00 0 00000000 0 0  0 0 0 0  0 0 0 0  00000

//--- all.f
naxi_pkg.sv
mon_pkg.sv
naxi_cmd_check.sv
naxi_pend_table.sv
naxi_resp_check.sv
naxi_slave_monitor.sv
tb_naxi_slave_monitor.sv

//--- Bender.yml
package:
  name: naxi_slave_monitor

sources:
  - naxi_pkg.sv
  - mon_pkg.sv
  - naxi_cmd_check.sv
  - naxi_pend_table.sv
  - naxi_resp_check.sv
  - naxi_slave_monitor.sv
  - target: simulation
    files:
      - tb_naxi_slave_monitor.sv
